/* design/hub75_pkg.sv */
package hub75_pkg;

    localparam int BRIGHTNESS_LEVELS = 5;  // bit planes, fixed by the 5-6-5 pixel

    // one framebuffer pixel, msb first
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // one framebuffer word, same column in both halves
    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    typedef struct packed {
        rgb_t       rgb1;       // top half
        rgb_t       rgb2;       // bottom half
        logic [3:0] row_addr;
        logic       clk_pixel;
        logic       row_latch;
        logic       oe_n;
    } hub75_out_t;

    typedef enum logic [7:0] {
        OP_PIXEL      = 8'h50,  // 'P'
        OP_RGB_ENABLE = 8'h52,  // 'R'
        OP_BRIGHTNESS = 8'h54   // 'T'
    } cmd_opcode_e;

    typedef enum logic [1:0] {
        SHIFT,
        BLANK,
        LATCH,
        SHOW
    } scan_state_e;

endpackage

/* design/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
    parameter int TICKS_PER_BIT = 4,
    localparam int CNT_W = $clog2(TICKS_PER_BIT + 1)
) (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [1:0]       rx_sync;   // two-flop synchronizer, [1] is safe to use
    logic [CNT_W-1:0] tick_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             mid_bit;
    logic             bit_end;

    assign mid_bit = tick_cnt == CNT_W'(TICKS_PER_BIT / 2 - 1);
    assign bit_end = tick_cnt == CNT_W'(TICKS_PER_BIT - 1);  // one bit after mid of start

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rx_sync  <= 2'b11;   // line idles high
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync[1])
                        state <= RX_START;
                end
                RX_START: begin
                    if (mid_bit) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync[1] ? RX_IDLE : RX_DATA;  // glitch, not a start bit
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        rx_valid <= rx_sync[1];  // framing error drops the byte
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && bit_end)
            shift_q <= {rx_sync[1], shift_q[7:1]};  // lsb first
        if (state == RX_STOP && bit_end)
            rx_data <= shift_q;
    end

    // a full frame lies between two bytes
    a_valid_pulse : assert property (@(posedge clk_in) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule

/* design/cmd_parser.sv */
`timescale 1ns/100ps

module cmd_parser
    import hub75_pkg::*;
#(
    parameter int PIXEL_WIDTH      = 8,
    parameter int PIXEL_HALFHEIGHT = 4,
    localparam int ADDR_W = $clog2(PIXEL_WIDTH * PIXEL_HALFHEIGHT)
) (
    input  logic                         clk_in,
    input  logic                         rst_n,
    input  logic [7:0]                   rx_data,
    input  logic                         rx_valid,
    output logic                         wr_en,
    output logic [ADDR_W-1:0]            wr_addr,
    output logic                         wr_bottom,
    output pixel_t                       wr_pixel,
    output rgb_t                         rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COL,
        ST_ROW,
        ST_HIGH,
        ST_LOW,
        ST_RGB,
        ST_BRIGHT
    } parse_state_e;

    parse_state_e state;
    logic [7:0]   col_q;
    logic [7:0]   row_q;
    logic [7:0]   high_q;
    logic         bottom;
    logic [7:0]   row_in_half;
    logic [15:0]  addr_full;
    logic         in_range;

    assign bottom      = int'(row_q) >= PIXEL_HALFHEIGHT;
    assign row_in_half = bottom ? row_q - 8'(PIXEL_HALFHEIGHT) : row_q;
    assign addr_full   = 16'(row_in_half) * 16'(PIXEL_WIDTH) + 16'(col_q);
    assign in_range    = (int'(col_q) < PIXEL_WIDTH) && (int'(row_q) < 2 * PIXEL_HALFHEIGHT);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state             <= ST_IDLE;
            wr_en             <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    ST_IDLE: begin
                        case (cmd_opcode_e'(rx_data))
                            OP_PIXEL:      state <= ST_COL;
                            OP_RGB_ENABLE: state <= ST_RGB;
                            OP_BRIGHTNESS: state <= ST_BRIGHT;
                            default:       state <= ST_IDLE;  // unknown byte
                        endcase
                    end
                    ST_COL:  state <= ST_ROW;
                    ST_ROW:  state <= ST_HIGH;
                    ST_HIGH: state <= ST_LOW;
                    ST_LOW: begin
                        wr_en <= in_range;  // out of range completes silently
                        state <= ST_IDLE;
                    end
                    ST_RGB: begin
                        rgb_enable <= rgb_t'(rx_data[2:0]);
                        state      <= ST_IDLE;
                    end
                    ST_BRIGHT: begin
                        brightness_enable <= rx_data[BRIGHTNESS_LEVELS-1:0];
                        state             <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // operand capture
    always_ff @(posedge clk_in) begin
        if (rx_valid) begin
            case (state)
                ST_COL:  col_q  <= rx_data;
                ST_ROW:  row_q  <= rx_data;
                ST_HIGH: high_q <= rx_data;
                ST_LOW: begin
                    wr_addr   <= addr_full[ADDR_W-1:0];
                    wr_bottom <= bottom;
                    wr_pixel  <= pixel_t'({high_q, rx_data});
                end
                default: ;
            endcase
        end
    end

    a_single_write : assert property (@(posedge clk_in) disable iff (!rst_n)
        wr_en |=> !wr_en);

endmodule

/* design/framebuffer.sv */
`timescale 1ns/100ps

module framebuffer
    import hub75_pkg::*;
#(
    parameter int PIXEL_WIDTH      = 8,
    parameter int PIXEL_HALFHEIGHT = 4,
    localparam int DEPTH  = PIXEL_WIDTH * PIXEL_HALFHEIGHT,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk_in,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic              wr_bottom,
    input  pixel_t            wr_pixel,
    input  logic [ADDR_W-1:0] rd_addr,
    output pixel_pair_t       rd_data
);

    pixel_pair_t mem [DEPTH];  // top and bottom half share one word

    // half-select write, the other half keeps its pixel
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_bottom)
                mem[wr_addr].bottom <= wr_pixel;
            else
                mem[wr_addr].top <= wr_pixel;
        end
    end

    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];  // one cycle read latency
    end

    // the parser range check must keep writes inside the panel
    a_wr_in_range : assert property (@(posedge clk_in)
        wr_en |-> int'(wr_addr) < DEPTH);

endmodule

/* design/pixel_fetch.sv */
`timescale 1ns/100ps

module pixel_fetch
    import hub75_pkg::*;
#(
    parameter int PIXEL_WIDTH      = 8,
    parameter int PIXEL_HALFHEIGHT = 4,
    localparam int COL_W  = $clog2(PIXEL_WIDTH),
    localparam int ROW_W  = $clog2(PIXEL_HALFHEIGHT),
    localparam int ADDR_W = $clog2(PIXEL_WIDTH * PIXEL_HALFHEIGHT)
) (
    input  logic                         clk_in,
    input  logic                         rst_n,
    input  logic                         pixel_load,
    input  logic [COL_W-1:0]             column,
    input  logic [ROW_W-1:0]             row,
    input  logic [2:0]                   plane,
    input  rgb_t                         rgb_enable,
    input  logic [BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic [ADDR_W-1:0]            rd_addr,
    input  pixel_pair_t                  rd_data,
    output rgb_t                         rgb1,
    output rgb_t                         rgb2
);

    logic [15:0] addr_full;
    logic        read_pending;  // rd_data holds the requested word

    // one plane bit per channel, masked by the enables
    function automatic rgb_t plane_bits(pixel_t pix, logic [2:0] p, rgb_t en,
                                        logic [BRIGHTNESS_LEVELS-1:0] br);
        rgb_t bits;
        bits.red   = pix.red[p] & en.red & br[p];
        bits.green = pix.green[p + 1] & en.green & br[p];  // green lsb is never shown
        bits.blue  = pix.blue[p] & en.blue & br[p];
        return bits;
    endfunction

    // column and row hold from the pulse, so the address is ready in the load cycle
    assign addr_full = 16'(row) * 16'(PIXEL_WIDTH) + 16'(column);
    assign rd_addr   = addr_full[ADDR_W-1:0];

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            read_pending <= 1'b0;
            rgb1         <= '0;
            rgb2         <= '0;
        end else begin
            read_pending <= pixel_load;
            if (read_pending) begin
                rgb1 <= plane_bits(rd_data.top, plane, rgb_enable, brightness_enable);
                rgb2 <= plane_bits(rd_data.bottom, plane, rgb_enable, brightness_enable);
            end
        end
    end

endmodule

/* design/matrix_scan.sv */
`timescale 1ns/100ps

module matrix_scan
    import hub75_pkg::*;
#(
    parameter int PIXEL_WIDTH      = 8,
    parameter int PIXEL_HALFHEIGHT = 4,
    parameter int SHOW_BASE        = 2,
    localparam int COL_W = $clog2(PIXEL_WIDTH),
    localparam int ROW_W = $clog2(PIXEL_HALFHEIGHT)
) (
    input  logic             clk_in,
    input  logic             rst_n,
    output logic             pixel_load,
    output logic [COL_W-1:0] column,
    output logic [ROW_W-1:0] row,
    output logic [2:0]       plane,
    output logic             clk_pixel,
    output logic             row_latch,
    output logic             oe_n,
    output logic [3:0]       row_addr
);

    localparam int SHOW_W = $clog2(SHOW_BASE << (BRIGHTNESS_LEVELS - 1)) + 1;

    scan_state_e       state;
    logic [1:0]        phase;     // four cycles per column
    logic [SHOW_W-1:0] show_cnt;

    assign pixel_load = (state == SHIFT) && (phase == 2'd0);
    assign clk_pixel  = (state == SHIFT) && (phase == 2'd3);  // data settled in phase 2
    assign row_latch  = (state == LATCH);
    assign oe_n       = (state != SHOW);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state    <= SHIFT;
            phase    <= '0;
            column   <= '0;
            row      <= '0;
            plane    <= '0;
            show_cnt <= '0;
            row_addr <= '0;
        end else begin
            case (state)
                SHIFT: begin
                    phase <= phase + 2'd1;
                    if (phase == 2'd3) begin
                        if (column == COL_W'(PIXEL_WIDTH - 1)) begin
                            column <= '0;
                            state  <= BLANK;
                        end else begin
                            column <= column + 1'b1;
                        end
                    end
                end
                BLANK: begin
                    row_addr <= 4'(row);  // shown from the latch on
                    state    <= LATCH;
                end
                LATCH: begin
                    // binary weighted display time
                    show_cnt <= SHOW_W'((SHOW_BASE << plane) - 1);
                    state    <= SHOW;
                end
                SHOW: begin
                    if (show_cnt == '0) begin
                        state <= SHIFT;
                        if (plane == 3'(BRIGHTNESS_LEVELS - 1)) begin
                            plane <= '0;
                            if (row == ROW_W'(PIXEL_HALFHEIGHT - 1))
                                row <= '0;
                            else
                                row <= row + 1'b1;
                        end else begin
                            plane <= plane + 3'd1;
                        end
                    end else begin
                        show_cnt <= show_cnt - 1'b1;
                    end
                end
                default: state <= SHIFT;
            endcase
        end
    end

    // panel must be dark across blank and latch
    a_latch_dark : assert property (@(posedge clk_in) disable iff (!rst_n)
        row_latch |-> oe_n && $past(oe_n));

endmodule

/* design/hub75_top.sv */
`timescale 1ns/100ps

module hub75_top
    import hub75_pkg::*;
#(
    parameter int PIXEL_WIDTH      = 8,
    parameter int PIXEL_HALFHEIGHT = 4,  // panel is twice this height
    parameter int TICKS_PER_BIT    = 4,
    parameter int SHOW_BASE        = 2
) (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       rx,
    output hub75_out_t panel
);

    localparam int COL_W  = $clog2(PIXEL_WIDTH);
    localparam int ROW_W  = $clog2(PIXEL_HALFHEIGHT);
    localparam int ADDR_W = $clog2(PIXEL_WIDTH * PIXEL_HALFHEIGHT);

    logic [7:0]                   rx_data;
    logic                         rx_valid;
    logic                         wr_en;
    logic [ADDR_W-1:0]            wr_addr;
    logic                         wr_bottom;
    pixel_t                       wr_pixel;
    rgb_t                         rgb_enable;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic [ADDR_W-1:0]            rd_addr;
    pixel_pair_t                  rd_data;
    logic                         pixel_load;
    logic [COL_W-1:0]             column;
    logic [ROW_W-1:0]             row;
    logic [2:0]                   plane;
    rgb_t                         rgb1;
    rgb_t                         rgb2;
    logic                         clk_pixel;
    logic                         row_latch;
    logic                         oe_n;
    logic [3:0]                   row_addr;

    uart_rx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) i_uart_rx (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    cmd_parser #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT (PIXEL_HALFHEIGHT)
    ) i_cmd_parser (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_bottom         (wr_bottom),
        .wr_pixel          (wr_pixel),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    framebuffer #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT (PIXEL_HALFHEIGHT)
    ) i_framebuffer (
        .clk_in    (clk_in),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_bottom (wr_bottom),
        .wr_pixel  (wr_pixel),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    pixel_fetch #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT (PIXEL_HALFHEIGHT)
    ) i_pixel_fetch (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .pixel_load        (pixel_load),
        .column            (column),
        .row               (row),
        .plane             (plane),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .rgb1              (rgb1),
        .rgb2              (rgb2)
    );

    matrix_scan #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT (PIXEL_HALFHEIGHT),
        .SHOW_BASE        (SHOW_BASE)
    ) i_matrix_scan (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .pixel_load (pixel_load),
        .column     (column),
        .row        (row),
        .plane      (plane),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n),
        .row_addr   (row_addr)
    );

    assign panel = '{
        rgb1:      rgb1,
        rgb2:      rgb2,
        row_addr:  row_addr,
        clk_pixel: clk_pixel,
        row_latch: row_latch,
        oe_n:      oe_n
    };

endmodule

/* tb/tb_hub75.sv */
`timescale 1ns/100ps

module tb_hub75
    import hub75_pkg::*;
();

    localparam int PW  = 8;
    localparam int PH  = 4;
    localparam int TPB = 4;
    localparam int SB  = 2;
    localparam int N_EXTRA = 6;  // random writes after the full fill
    localparam int N_CMD   = 2 * PH * PW + N_EXTRA + 4;
    localparam int LATCHES_PER_FRAME = PH * BRIGHTNESS_LEVELS;
    localparam int FRAME_CYCLES =
        PH * (BRIGHTNESS_LEVELS * (4 * PW + 2) + SB * ((1 << BRIGHTNESS_LEVELS) - 1));
    localparam int TEST_FRAMES = 10;
    localparam int TIMEOUT_CYCLES = (N_CMD * 5 * 11 * TPB + TEST_FRAMES * FRAME_CYCLES) * 2;

    logic       clk_in;
    logic       rst_n;
    logic       rx;
    hub75_out_t panel;

    pixel_t                       model_top [PW * PH];
    pixel_t                       model_bot [PW * PH];
    rgb_t                         model_en;
    logic [BRIGHTNESS_LEVELS-1:0] model_br;
    logic [31:0]                  lcg_state;
    logic                         check_en;
    logic                         rst_seen = 1'b0;
    int col_cnt;       // clk_pixel edges since the last latch
    int t_row;         // row and plane being shifted
    int t_plane;
    int shown_plane;
    int low_cnt;
    int pix_idx;
    int n_checked = 0;
    int cycle_cnt = 0;
    int err_reset = 0;
    int err_scan  = 0;
    int err_data  = 0;
    rgb_t exp_rgb1;
    rgb_t exp_rgb2;

    hub75_top #(
        .PIXEL_WIDTH      (PW),
        .PIXEL_HALFHEIGHT (PH),
        .TICKS_PER_BIT    (TPB),
        .SHOW_BASE        (SB)
    ) i_dut (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .rx     (rx),
        .panel  (panel)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    function automatic rgb_t expected_color(pixel_t pix, int p, rgb_t en,
                                            logic [BRIGHTNESS_LEVELS-1:0] br);
        rgb_t c;
        c.red   = pix.red[p] && en.red && br[p];
        c.green = pix.green[p + 1] && en.green && br[p];  // 6-bit green, top five planes
        c.blue  = pix.blue[p] && en.blue && br[p];
        return c;
    endfunction

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    assign pix_idx  = (t_row * PW + col_cnt) % (PW * PH);
    assign exp_rgb1 = expected_color(model_top[pix_idx], t_plane, model_en, model_br);
    assign exp_rgb2 = expected_color(model_bot[pix_idx], t_plane, model_en, model_br);

    // follow the scan from the panel pins
    always @(posedge clk_in) begin
        if (!rst_n) begin
            rst_seen    <= 1'b1;
            col_cnt     <= 0;
            t_row       <= 0;
            t_plane     <= 0;
            shown_plane <= 0;
            low_cnt     <= 0;
        end else begin
            if (panel.clk_pixel)
                col_cnt <= col_cnt + 1;
            if (!panel.oe_n)
                low_cnt <= low_cnt + 1;
            if (check_en && panel.clk_pixel)
                n_checked <= n_checked + 1;
            if (panel.row_latch) begin
                col_cnt     <= 0;
                low_cnt     <= 0;
                shown_plane <= t_plane;
                if (t_plane == BRIGHTNESS_LEVELS - 1) begin
                    t_plane <= 0;
                    t_row   <= (t_row == PH - 1) ? 0 : t_row + 1;
                end else begin
                    t_plane <= t_plane + 1;
                end
            end
        end
    end

    a_reset_idle : assert property (@(posedge clk_in)
        rst_seen && (!rst_n || $past(!rst_n)) |->
            panel.oe_n && !panel.clk_pixel && !panel.row_latch &&
            panel.rgb1 == 3'b0 && panel.rgb2 == 3'b0)
        else begin
            err_reset++;
            $display("outputs not idle during or right after reset");
        end

    a_col_count : assert property (@(posedge clk_in) disable iff (!rst_n)
        panel.row_latch |-> col_cnt == PW)
        else begin
            err_scan++;
            $display("[FAIL] clk_pixel count expected %h got %h", PW, $sampled(col_cnt));
        end

    a_row_addr : assert property (@(posedge clk_in) disable iff (!rst_n)
        panel.row_latch |-> panel.row_addr == 4'(t_row))
        else begin
            err_scan++;
            $display("[FAIL] row_addr expected %h got %h", $sampled(t_row),
                     $sampled(panel.row_addr));
        end

    a_show_len : assert property (@(posedge clk_in) disable iff (!rst_n)
        panel.oe_n && !$past(panel.oe_n) |-> low_cnt == (SB << shown_plane))
        else begin
            err_scan++;
            $display("[FAIL] oe_n low cycles expected %h got %h",
                     SB << $sampled(shown_plane), $sampled(low_cnt));
        end

    a_rgb1 : assert property (@(posedge clk_in) disable iff (!rst_n)
        check_en && panel.clk_pixel |-> panel.rgb1 == exp_rgb1)
        else begin
            err_data++;
            $display("[FAIL] rgb1 expected %h got %h", $sampled(exp_rgb1),
                     $sampled(panel.rgb1));
        end

    a_rgb2 : assert property (@(posedge clk_in) disable iff (!rst_n)
        check_en && panel.clk_pixel |-> panel.rgb2 == exp_rgb2)
        else begin
            err_data++;
            $display("[FAIL] rgb2 expected %h got %h", $sampled(exp_rgb2),
                     $sampled(panel.rgb2));
        end

    // disabled channel stays dark in both halves
    a_channel_off : assert property (@(posedge clk_in) disable iff (!rst_n)
        check_en && panel.clk_pixel |-> ((panel.rgb1 | panel.rgb2) & ~model_en) == 3'b0)
        else begin
            err_data++;
            $display("[FAIL] rgb1|rgb2 masked expected %h got %h", 3'h0,
                     $sampled((panel.rgb1 | panel.rgb2) & ~model_en));
        end

    a_plane_off : assert property (@(posedge clk_in) disable iff (!rst_n)
        check_en && panel.clk_pixel && !model_br[t_plane] |->
            panel.rgb1 == 3'b0 && panel.rgb2 == 3'b0)
        else begin
            err_data++;
            $display("[FAIL] rgb1,rgb2 expected %h got %h", 6'h0,
                     $sampled({panel.rgb1, panel.rgb2}));
        end

    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, stimulus did not complete", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // one 8N1 frame plus an idle bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (TPB) @(negedge clk_in);
        end
        repeat (TPB) @(negedge clk_in);
    endtask

    task automatic send_pixel(input int col, input int row, input pixel_t pix);
        send_byte(OP_PIXEL);
        send_byte(8'(col));
        send_byte(8'(row));
        send_byte(pix[15:8]);
        send_byte(pix[7:0]);
        if (col < PW && row < PH)
            model_top[row * PW + col] = pix;
        else if (col < PW && row < 2 * PH)
            model_bot[(row - PH) * PW + col] = pix;
    endtask

    task automatic wait_latches(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk_in);
            if (panel.row_latch)
                seen++;
        end
    endtask

    // let a whole frame pass on the new contents, then check n frames
    task automatic check_frames(input int n);
        wait_latches(LATCHES_PER_FRAME + 1);
        check_en = 1'b1;
        wait_latches(n * LATCHES_PER_FRAME);
        check_en = 1'b0;
    endtask

    task automatic finish_run();
        int total;
        total = err_reset + err_scan + err_data;
        if (n_checked == 0) begin
            $display("no pixel was ever checked");
            total++;
        end
        $display("errors: reset %0d, scan %0d, data %0d", err_reset, err_scan, err_data);
        if (total == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    endtask

    initial begin
        rx        = 1'b1;
        rst_n     = 1'b0;
        check_en  = 1'b0;
        lcg_state = 32'd7;
        model_en  = '1;
        model_br  = '1;
        repeat (8) @(negedge clk_in);
        rst_n = 1'b1;

        // memory has no reset, so fill every pixel first
        for (int r = 0; r < 2 * PH; r++)
            for (int c = 0; c < PW; c++)
                send_pixel(c, r, pixel_t'(next_rand()));
        for (int i = 0; i < N_EXTRA; i++)
            send_pixel(next_rand() % PW, next_rand() % (2 * PH), pixel_t'(next_rand()));
        send_pixel(PW + 2, 1, 16'hffff);  // out of range, no write
        check_frames(2);

        send_byte(8'h41);
        send_byte(8'h51);
        send_byte(8'ha5);
        send_byte(OP_RGB_ENABLE);
        send_byte(8'h05);                 // green off
        model_en = 3'b101;
        check_frames(1);

        send_byte(OP_BRIGHTNESS);
        send_byte(8'h16);                 // planes 0 and 3 off
        model_br = 5'b10110;
        check_frames(1);

        finish_run();
    end

endmodule

/* compile.f */
design/hub75_pkg.sv
design/uart_rx.sv
design/cmd_parser.sv
design/framebuffer.sv
design/pixel_fetch.sv
design/matrix_scan.sv
design/hub75_top.sv
tb/tb_hub75.sv
